// File: src/cart_quirk_table.svh
// Per-title quirk table keyed on the product ID
// quirk_lookup returns the first matching save or bus quirk
// gun_lookup returns the light-gun type and sensor delay
`ifndef CART_QUIRK_TABLE_SVH
`define CART_QUIRK_TABLE_SVH

// Only one of the outputs is non-zero for a matching title
function automatic void quirk_lookup(
	input  cart_id_t    id,
	input  crc_t        crc,
	output eeprom_map_t eeprom,
	output logic        bank_eeprom,
	output logic        noram,
	output logic        pier,
	output logic        svp,
	output logic        fmbusy,
	output logic        schan,
	output sf_map_t     sf
);
	eeprom      = '0;
	bank_eeprom = 1'b0;
	noram       = 1'b0;
	pier        = 1'b0;
	svp         = 1'b0;
	fmbusy      = 1'b0;
	schan       = 1'b0;
	sf          = '0;
	case (id[63:0])
		// Banked EEPROM sports titles
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
			bank_eeprom = 1'b1;
		// EA serial EEPROM
		"T-50446 ", "T-50516 ", "T-50396 ", "T-50176 ", "T-50606 ":
			eeprom = 3'b001;
		// Sega style serial EEPROM
		"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
		"00004076", "T-12046 ", "T-12053 ", "G-4524  ", "00054503":
			eeprom = 3'b010;
		"T-81033 ", "T-081326": eeprom = 3'b011;    // NBA Jam
		"T-113016": noram = 1'b1;                   // Fake RAM check
		"T-574023", "T-574013": pier = 1'b1;
		"MK-1229 ", "G-7001  ": svp = 1'b1;         // Virtua Racing
		"T-35036 ", "T-25073 ", "MK-1137-": fmbusy = 1'b1;
		"T-68???-": schan = 1'b1;
		default: begin
			// Unlicensed mappers match on the leading six characters
			if (id[87:40] == "SF-001") begin
				sf = {crc == 16'h3E08, 2'b01};   // Revision told apart by checksum
			end else if (id[87:40] == "SF-002") begin
				sf = 3'b110;
			end else if (id[87:40] == "SF-004") begin
				sf = 3'b111;
			end
		end
	endcase
endfunction

// Titles not listed fall back to the Menacer type and the default delay
function automatic void gun_lookup(
	input  cart_id_t   id,
	output logic       gun,
	output gun_delay_t delay
);
	gun   = 1'b0;
	delay = GUN_DELAY_DEFAULT;
	case (id[63:0])
		"MK-1533 ": delay = 8'd100;   // Body Count
		"T-95096-": begin             // Lethal Enforcers
			gun   = 1'b1;
			delay = 8'd52;
		end
		"T-95136-": begin             // Lethal Enforcers II
			gun   = 1'b1;
			delay = 8'd30;
		end
		"MK-1658 ": delay = 8'd120;   // Menacer 6-in-1
		"T-081156": delay = 8'd126;   // T2 arcade
		default: ;
	endcase
endfunction

`endif

// File: src/cart_hdr_pkg.sv
// Cartridge header inspection shared definitions
// Widths of the download port and the header fields
// Region codes
// Header and secondary ID byte offsets
// Power-up defaults
package cart_hdr_pkg;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	typedef logic [24:0] dl_addr_t;     // Byte address of a download word
	typedef logic [15:0] dl_word_t;     // One download word
	typedef logic [87:0] cart_id_t;     // Product ID, 11 characters
	typedef logic [15:0] crc_t;         // Header checksum
	typedef logic [1:0]  region_t;      // Console region code
	typedef logic [2:0]  eeprom_map_t;  // Save EEPROM wiring variant
	typedef logic [2:0]  sf_map_t;      // Unlicensed mapper variant
	typedef logic [7:0]  gun_delay_t;   // Light-gun sensor delay in pixel clocks

	////////////////////////////////////////
	// Region codes
	////////////////////////////////////////

	localparam region_t REGION_JP = 2'd0;
	localparam region_t REGION_US = 2'd1;
	localparam region_t REGION_EU = 2'd2;

	////////////////////////////////////////
	// Header offsets
	////////////////////////////////////////

	// Region characters
	localparam dl_addr_t HDR_REGION_A = 25'h1F0;   // Two region characters
	localparam dl_addr_t HDR_REGION_B = 25'h1F2;   // Third region character in the low byte

	// Product ID words, byte swapped on the bus
	localparam dl_addr_t HDR_ID_BASE  = 25'h180;
	localparam dl_addr_t HDR_ID_LAST  = 25'h18A;   // Only the low byte is part of the ID

	localparam dl_addr_t HDR_CRC      = 25'h18E;
	localparam dl_addr_t HDR_ID_DONE  = 25'h190;   // First word after the ID block
	localparam dl_addr_t HDR_END      = 25'h200;   // Header fully received

	// Secondary ID block of the Realtec mapper titles
	localparam dl_addr_t RTC_ID_HI    = 25'h7E100;
	localparam dl_addr_t RTC_ID_LO    = 25'h7E102;
	localparam dl_addr_t RTC_ID_DONE  = 25'h7E104;

	////////////////////////////////////////
	// Defaults
	////////////////////////////////////////

	// Sensor delay for titles with no known gun timing
	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

endpackage

// File: src/dl_word_capture.sv
// Download stream capture
// Registers each accepted write and flags the start and end of a download
`timescale 1ns/10ps

module dl_word_capture (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_download,
	input  logic                   dl_wr,
	input  cart_hdr_pkg::dl_addr_t dl_addr,
	input  cart_hdr_pkg::dl_word_t dl_data,
	output logic                   dl_start,
	output logic                   dl_end,
	output logic                   word_wr,
	output cart_hdr_pkg::dl_addr_t word_addr,
	output cart_hdr_pkg::dl_word_t word_data
);

	logic dl_q;   // Download level, one cycle back
	logic wr_ok;

	// Writes outside a download are ignored
	assign wr_ok = dl_wr & cart_download;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q     <= 1'b0;
			dl_start <= 1'b0;
			dl_end   <= 1'b0;
			word_wr  <= 1'b0;
		end else begin
			dl_q     <= cart_download;
			dl_start <= cart_download & ~dl_q;   // Rising edge
			dl_end   <= dl_q & ~cart_download;   // Falling edge
			word_wr  <= wr_ok;
		end
	end

	// Address only moves on a write, so it still holds
	// the last word's address when the download ends
	always_ff @(posedge clk_sys) begin
		if (wr_ok) begin
			word_addr <= dl_addr;
			word_data <= dl_data;
		end
	end

endmodule

// File: src/header_field_latch.sv
// Header field latch
// Collects the product ID, checksum and secondary ID words
// Decodes the region characters into J/U/E flags
// Raises the ID and header done events and records the ROM size
`timescale 1ns/10ps

module header_field_latch (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   dl_start,
	input  logic                   dl_end,
	input  logic                   word_wr,
	input  cart_hdr_pkg::dl_addr_t word_addr,
	input  cart_hdr_pkg::dl_word_t word_data,
	output cart_hdr_pkg::cart_id_t cart_id,
	output cart_hdr_pkg::crc_t     id_crc,
	output logic                   id_done,
	output logic [31:0]            rtc_id,
	output logic                   rtc_done,
	output logic                   hdr_j,
	output logic                   hdr_u,
	output logic                   hdr_e,
	output logic                   hdr_ready,
	output cart_hdr_pkg::dl_addr_t rom_sz
);
	import cart_hdr_pkg::*;

	// One-hot {E,U,J} for a region letter, zero otherwise
	function automatic logic [2:0] letter_bits(input logic [7:0] c);
		return {c == "E", c == "U", c == "J"};
	endfunction

	dl_word_t   swapped;     // Header text is big endian
	dl_addr_t   id_off;
	logic       id_word_wr;
	logic [3:0] hrgn;        // Hex digit value of 'A'..'F'
	logic [2:0] lo_letter;
	logic [2:0] hi_letter;
	logic [2:0] flags_nxt;   // {E,U,J}
	logic       region_a_wr;
	logic       region_b_wr;

	assign swapped    = {word_data[7:0], word_data[15:8]};
	assign id_off     = word_addr - HDR_ID_BASE;
	assign id_word_wr = word_wr && (word_addr >= HDR_ID_BASE) && (word_addr < HDR_ID_LAST)
		&& !word_addr[0];

	////////////////////////////////////////
	// Region characters
	////////////////////////////////////////

	assign hrgn        = word_data[3:0] - 4'd7;
	assign lo_letter   = letter_bits(word_data[7:0]);
	assign hi_letter   = letter_bits(word_data[15:8]);
	assign region_a_wr = word_wr && (word_addr == HDR_REGION_A);
	assign region_b_wr = word_wr && (word_addr == HDR_REGION_B);

	always_comb begin
		flags_nxt = {hdr_e, hdr_u, hdr_j};
		if (region_a_wr) begin
			if (|lo_letter) begin
				flags_nxt = flags_nxt | lo_letter;
			end else if (word_data[7:0] >= "0" && word_data[7:0] <= "9") begin
				flags_nxt = {word_data[3], word_data[2], word_data[0]};   // Numeric region mask
			end else if (word_data[7:0] >= "A" && word_data[7:0] <= "F") begin
				flags_nxt = {hrgn[3], hrgn[2], hrgn[0]};
			end
			flags_nxt = flags_nxt | hi_letter;   // High byte is letters only
		end
		if (region_b_wr)
			flags_nxt = flags_nxt | lo_letter;
	end

	////////////////////////////////////////
	// Control and events
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			{hdr_e, hdr_u, hdr_j} <= '0;
			id_done   <= 1'b0;
			rtc_done  <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			id_done  <= word_wr && (word_addr == HDR_ID_DONE);
			rtc_done <= word_wr && (word_addr == RTC_ID_DONE);
			if (dl_start)
				{hdr_e, hdr_u, hdr_j} <= '0;
			else
				{hdr_e, hdr_u, hdr_j} <= flags_nxt;
			if (word_wr && (word_addr == HDR_END))
				hdr_ready <= 1'b1;
			if (dl_end)
				hdr_ready <= 1'b0;
		end
	end

	// Header payload
	always_ff @(posedge clk_sys) begin
		if (id_word_wr)
			cart_id[87 - 16 * id_off[3:1] -: 16] <= swapped;
		if (word_wr && (word_addr == HDR_ID_LAST))
			cart_id[7:0] <= word_data[7:0];   // Eleventh character
		if (word_wr && (word_addr == HDR_CRC))
			id_crc <= swapped;
		if (word_wr && (word_addr == RTC_ID_HI))
			rtc_id[31:16] <= swapped;
		if (word_wr && (word_addr == RTC_ID_LO))
			rtc_id[15:0] <= swapped;
		if (dl_end)
			rom_sz <= word_addr;   // Last address written
	end

endmodule

// File: src/cart_quirk_decode.sv
// Cartridge quirk decode
// Looks the product ID up in the quirk table on the ID done event
// Picks the light-gun settings and the Realtec mapper flag
`timescale 1ns/10ps

module cart_quirk_decode (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      dl_start,
	input  cart_hdr_pkg::cart_id_t    cart_id,
	input  cart_hdr_pkg::crc_t        id_crc,
	input  logic                      id_done,
	input  logic [31:0]               rtc_id,
	input  logic                      rtc_done,
	output cart_hdr_pkg::eeprom_map_t eeprom_map,
	output logic                      bank_eeprom_quirk,
	output logic                      noram_quirk,
	output logic                      pier_quirk,
	output logic                      svp_quirk,
	output logic                      fmbusy_quirk,
	output logic                      schan_quirk,
	output cart_hdr_pkg::sf_map_t     sf_map,
	output logic                      realtec_map,
	output logic                      gun_type,
	output cart_hdr_pkg::gun_delay_t  gun_sensor_delay
);
	import cart_hdr_pkg::*;

	`include "cart_quirk_table.svh"

	// Table lookup results
	eeprom_map_t q_eeprom;
	logic        q_bank;
	logic        q_noram;
	logic        q_pier;
	logic        q_svp;
	logic        q_fmbusy;
	logic        q_schan;
	sf_map_t     q_sf;
	logic        q_gun;
	gun_delay_t  q_delay;

	always_comb begin
		quirk_lookup(cart_id, id_crc, q_eeprom, q_bank, q_noram, q_pier,
			q_svp, q_fmbusy, q_schan, q_sf);
		gun_lookup(cart_id, q_gun, q_delay);
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || dl_start) begin
			eeprom_map        <= '0;
			bank_eeprom_quirk <= 1'b0;
			noram_quirk       <= 1'b0;
			pier_quirk        <= 1'b0;
			svp_quirk         <= 1'b0;
			fmbusy_quirk      <= 1'b0;
			schan_quirk       <= 1'b0;
			sf_map            <= '0;
			realtec_map       <= 1'b0;
		end else begin
			if (id_done) begin
				if (q_eeprom != '0) eeprom_map <= q_eeprom;
				if (q_bank)         bank_eeprom_quirk <= 1'b1;
				if (q_noram)        noram_quirk <= 1'b1;
				if (q_pier)         pier_quirk <= 1'b1;
				if (q_svp)          svp_quirk <= 1'b1;
				if (q_fmbusy)       fmbusy_quirk <= 1'b1;
				if (q_schan)        schan_quirk <= 1'b1;
				if (q_sf != '0)     sf_map <= q_sf;
			end
			if (rtc_done && rtc_id == "SEGA")
				realtec_map <= 1'b1;   // Realtec boards carry a second signature
		end
	end

	// Gun settings survive a new download until its ID arrives
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			gun_type         <= 1'b0;
			gun_sensor_delay <= GUN_DELAY_DEFAULT;
		end else if (id_done) begin
			gun_type         <= q_gun;
			gun_sensor_delay <= q_delay;
		end
	end

endmodule

// File: src/region_resolver.sv
// Region resolver
// Chooses the console region from the header flags once the header is in
// Priority order is selectable, region_set is held while the header is valid
`timescale 1ns/10ps

module region_resolver (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  hdr_ready,
	input  logic                  hdr_j,
	input  logic                  hdr_u,
	input  logic                  hdr_e,
	input  logic                  auto_region_off,
	input  logic [1:0]            region_priority,
	output cart_hdr_pkg::region_t region_req,
	output logic                  region_set
);
	import cart_hdr_pkg::*;

	// First present region in the chosen order, else the order's head
	function automatic region_t pick_region(
		input logic [1:0] prio,
		input logic [2:0] present   // Indexed by region code
	);
		region_t order [0:2];
		region_t pick;
		case (prio)
			2'd0:    order = '{REGION_US, REGION_EU, REGION_JP};
			2'd1:    order = '{REGION_EU, REGION_US, REGION_JP};
			2'd2:    order = '{REGION_US, REGION_JP, REGION_EU};
			default: order = '{REGION_JP, REGION_US, REGION_EU};
		endcase
		pick = order[0];
		// Walk backwards so the earliest match is kept
		for (int i = 2; i >= 0; i--) begin
			if (present[order[i]])
				pick = order[i];
		end
		return pick;
	endfunction

	logic ready_q;
	logic ready_rise;
	logic ready_fall;

	assign ready_rise = hdr_ready & ~ready_q;
	assign ready_fall = ready_q & ~hdr_ready;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_q    <= 1'b0;
			region_set <= 1'b0;
			region_req <= REGION_JP;
		end else begin
			ready_q <= hdr_ready;
			if (ready_rise && !auto_region_off) begin
				region_set <= 1'b1;
				region_req <= pick_region(region_priority, {hdr_e, hdr_u, hdr_j});
			end
			if (ready_fall)
				region_set <= 1'b0;   // Download finished
		end
	end

endmodule

// File: src/cart_header_top.sv
// Cartridge header inspection top level
// Download capture, header latch, quirk decode and region resolver
`timescale 1ns/10ps

module cart_header_top (
	input  logic                      clk_sys,
	input  logic                      RESET,
	input  logic                      cart_download,
	input  logic                      dl_wr,
	input  cart_hdr_pkg::dl_addr_t    dl_addr,
	input  cart_hdr_pkg::dl_word_t    dl_data,
	input  logic                      auto_region_off,
	input  logic [1:0]                region_priority,
	output cart_hdr_pkg::dl_addr_t    rom_sz,
	output cart_hdr_pkg::eeprom_map_t eeprom_map,
	output logic                      bank_eeprom_quirk,
	output logic                      noram_quirk,
	output logic                      pier_quirk,
	output logic                      svp_quirk,
	output logic                      fmbusy_quirk,
	output logic                      schan_quirk,
	output cart_hdr_pkg::sf_map_t     sf_map,
	output logic                      realtec_map,
	output logic                      gun_type,
	output cart_hdr_pkg::gun_delay_t  gun_sensor_delay,
	output cart_hdr_pkg::region_t     region_req,
	output logic                      region_set
);
	import cart_hdr_pkg::*;

	// Capture to latch
	logic     dl_start;
	logic     dl_end;
	logic     word_wr;
	dl_addr_t word_addr;
	dl_word_t word_data;

	// Latch to decode and resolver
	cart_id_t    cart_id;
	crc_t        id_crc;
	logic        id_done;
	logic [31:0] rtc_id;
	logic        rtc_done;
	logic        hdr_j;
	logic        hdr_u;
	logic        hdr_e;
	logic        hdr_ready;

	dl_word_capture capture_i (.*);

	header_field_latch latch_i (.*);

	cart_quirk_decode quirk_i (.*);

	region_resolver region_i (.*);

endmodule

// File: sim/tb_cart_header.sv
// Testbench for the cartridge header inspection top level
// Header image builder and word streamer with random gaps
// Reference model of quirks, gun settings, region and ROM size
// Compare process and cycle-count timeout
`timescale 1ns/10ps

module tb_cart_header;
	import cart_hdr_pkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int NUM_DOWNLOADS = 44;
	localparam int MAX_WORDS     = 75;   // Header, secondary ID and longest tail
	localparam int MAX_GAP       = 2;
	localparam int DL_OVERHEAD   = 12;   // Start, settle and end cycles
	localparam int CYCLE_LIMIT   = RESET_CYCLES + 200
		+ NUM_DOWNLOADS * (MAX_WORDS * (MAX_GAP + 1) + DL_OVERHEAD);

	localparam cart_id_t PLAIN_ID = "GM 12345678";   // Not in any table

	// DUT ports
	logic        clk_sys;
	logic        RESET;
	logic        cart_download;
	logic        dl_wr;
	dl_addr_t    dl_addr;
	dl_word_t    dl_data;
	logic        auto_region_off;
	logic [1:0]  region_priority;
	dl_addr_t    rom_sz;
	eeprom_map_t eeprom_map;
	logic        bank_eeprom_quirk;
	logic        noram_quirk;
	logic        pier_quirk;
	logic        svp_quirk;
	logic        fmbusy_quirk;
	logic        schan_quirk;
	sf_map_t     sf_map;
	logic        realtec_map;
	logic        gun_type;
	gun_delay_t  gun_sensor_delay;
	region_t     region_req;
	logic        region_set;

	// Expected values
	eeprom_map_t exp_eeprom;
	logic        exp_bank;
	logic        exp_noram;
	logic        exp_pier;
	logic        exp_svp;
	logic        exp_fmbusy;
	logic        exp_schan;
	sf_map_t     exp_sf;
	logic        exp_realtec;
	logic        exp_gun;
	gun_delay_t  exp_delay;
	region_t     exp_region;
	dl_addr_t    exp_rom_sz;
	logic        exp_set;
	logic        check_rom;

	logic [7:0]  img [0:255];   // Header bytes from 0x180 on
	logic [31:0] rng;
	int          err_cnt;
	int          check_cnt;
	int          cycle_cnt;
	event        check_ev;
	event        check_done;

	logic [23:0] letter_codes [4] = '{"JUE", "EJ ", "  U", "   "};
	logic [23:0] digit_codes  [5] = '{"4  ", "A  ", "5  ", "B  ", "4E "};
	cart_id_t    quirk_ids    [13] = '{"GM T-081276", "GM T-50446 ", "GM MK-1215 ",
		"GM T-81033 ", "GM T-113016", "GM T-574023", "GM MK-1229 ", "GM T-35036 ",
		"GM T-68???-", "SF-001 TEST", "SF-001 TEST", "SF-002 TEST", "SF-004 TEST"};
	crc_t        quirk_crcs   [13] = '{16'h1000, 16'h1001, 16'h1002, 16'h1003, 16'h1004,
		16'h1005, 16'h1006, 16'h1007, 16'h1008, 16'h3E08, 16'h3E09, 16'h1009, 16'h100A};
	cart_id_t    gun_ids      [6] = '{"GM MK-1533 ", "GM T-95096-", "GM T-95136-",
		"GM MK-1658 ", "GM T-081156", PLAIN_ID};

	cart_header_top dut_i (.*);

	always #5 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// {eeprom[2:0], bank, noram, pier, svp, fmbusy, schan, sf[2:0]}
	function automatic logic [11:0] title_quirks(input cart_id_t id, input crc_t crc);
		logic [11:0] q;
		q = 12'h000;
		case (id)
			"GM T-081276": q = 12'b000_100000_000;
			"GM T-50446 ": q = 12'b001_000000_000;
			"GM MK-1215 ": q = 12'b010_000000_000;
			"GM T-81033 ": q = 12'b011_000000_000;
			"GM T-113016": q = 12'b000_010000_000;
			"GM T-574023": q = 12'b000_001000_000;
			"GM MK-1229 ": q = 12'b000_000100_000;
			"GM T-35036 ": q = 12'b000_000010_000;
			"GM T-68???-": q = 12'b000_000001_000;
			default: begin
				if (id[87:40] == "SF-001")
					q[2:0] = (crc == 16'h3E08) ? 3'b101 : 3'b001;
				else if (id[87:40] == "SF-002")
					q[2:0] = 3'b110;
				else if (id[87:40] == "SF-004")
					q[2:0] = 3'b111;
			end
		endcase
		return q;
	endfunction

	// {gun_type, delay}
	function automatic logic [8:0] title_gun(input cart_id_t id);
		case (id)
			"GM MK-1533 ": return {1'b0, 8'd100};
			"GM T-95096-": return {1'b1, 8'd52};
			"GM T-95136-": return {1'b1, 8'd30};
			"GM MK-1658 ": return {1'b0, 8'd120};
			"GM T-081156": return {1'b0, 8'd126};
			default:       return {1'b0, GUN_DELAY_DEFAULT};
		endcase
	endfunction

	function automatic logic [2:0] letter_flag(input logic [7:0] c);
		case (c)
			"J":     return 3'b001;
			"U":     return 3'b010;
			"E":     return 3'b100;
			default: return 3'b000;
		endcase
	endfunction

	// Flags as {E,U,J} from the three region characters
	function automatic logic [2:0] region_flags(input logic [7:0] c0, input logic [7:0] c1,
			input logic [7:0] c2);
		logic [2:0] f;
		logic [3:0] v;
		f = letter_flag(c0);
		if (f == 3'b000 && c0 >= "0" && c0 <= "9") begin
			v = 4'(c0 - "0");
			f = {v[3], v[2], v[0]};
		end else if (f == 3'b000 && c0 >= "A" && c0 <= "F") begin
			v = 4'(c0 - "A" + 8'd10);   // Hex digit value
			f = {v[3], v[2], v[0]};
		end
		return f | letter_flag(c1) | letter_flag(c2);
	endfunction

	function automatic region_t choose_region(input logic [1:0] prio, input logic [2:0] f);
		logic j;
		logic u;
		logic e;
		{e, u, j} = f;
		case (prio)
			2'd0:    return u ? REGION_US : e ? REGION_EU : j ? REGION_JP : REGION_US;
			2'd1:    return e ? REGION_EU : u ? REGION_US : j ? REGION_JP : REGION_EU;
			2'd2:    return u ? REGION_US : j ? REGION_JP : e ? REGION_EU : REGION_US;
			default: return j ? REGION_JP : u ? REGION_US : e ? REGION_EU : REGION_JP;
		endcase
	endfunction

	// {quirks[11:0], realtec, gun, delay[7:0], region[1:0], rom_sz[24:0]}
	function automatic logic [48:0] predict_result(
		input cart_id_t    id,
		input crc_t        crc,
		input logic [23:0] rgn,
		input logic        rtc_on,
		input logic [31:0] rtc_txt,
		input logic [1:0]  prio,
		input logic        auto_off,
		input region_t     prev_region,
		input dl_addr_t    last_addr
	);
		logic [2:0] f;
		region_t    r;
		logic       rt;
		f  = region_flags(rgn[23:16], rgn[15:8], rgn[7:0]);
		r  = auto_off ? prev_region : choose_region(prio, f);   // Old region is kept
		rt = rtc_on && (rtc_txt == "SEGA");
		return {title_quirks(id, crc), rt, title_gun(id), r, last_addr};
	endfunction

	////////////////////////////////////////
	// Compare process
	////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_cnt++;
		assert (got === exp) else begin
			err_cnt++;
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	always begin
		@(check_ev);
		check_value("eeprom_map", 32'(eeprom_map), 32'(exp_eeprom));
		check_value("bank_eeprom_quirk", 32'(bank_eeprom_quirk), 32'(exp_bank));
		check_value("noram_quirk", 32'(noram_quirk), 32'(exp_noram));
		check_value("pier_quirk", 32'(pier_quirk), 32'(exp_pier));
		check_value("svp_quirk", 32'(svp_quirk), 32'(exp_svp));
		check_value("fmbusy_quirk", 32'(fmbusy_quirk), 32'(exp_fmbusy));
		check_value("schan_quirk", 32'(schan_quirk), 32'(exp_schan));
		check_value("sf_map", 32'(sf_map), 32'(exp_sf));
		check_value("realtec_map", 32'(realtec_map), 32'(exp_realtec));
		check_value("gun_type", 32'(gun_type), 32'(exp_gun));
		check_value("gun_sensor_delay", 32'(gun_sensor_delay), 32'(exp_delay));
		check_value("region_req", 32'(region_req), 32'(exp_region));
		check_value("region_set", 32'(region_set), 32'(exp_set));
		if (check_rom)
			check_value("rom_sz", 32'(rom_sz), 32'(exp_rom_sz));
		-> check_done;
	end

	task automatic request_check(input logic set_exp, input logic rom_on);
		exp_set   = set_exp;
		check_rom = rom_on;
		-> check_ev;
		@(check_done);
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Starts and returns on a falling edge
	task automatic write_word(input dl_addr_t a, input dl_word_t d);
		int gap;
		rng = xorshift32(rng);
		gap = int'(rng % 32'd3);
		repeat (gap) @(negedge clk_sys);
		dl_wr   = 1'b1;
		dl_addr = a;
		dl_data = d;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic build_image(input cart_id_t id, input crc_t crc, input logic [23:0] rgn);
		dl_addr_t a;
		for (int i = 0; i < 256; i++) begin
			a = HDR_ID_BASE + 25'(i);
			img[8'(i)] = 8'(a ^ (a >> 8) ^ (a >> 16));
		end
		for (int k = 0; k < 11; k++)
			img[8'(k)] = id[87 - 8 * k -: 8];
		img[8'h0E] = crc[15:8];
		img[8'h0F] = crc[7:0];
		img[8'h70] = rgn[23:16];
		img[8'h71] = rgn[15:8];
		img[8'h72] = rgn[7:0];
	endtask

	task automatic run_download(input cart_id_t id, input crc_t crc, input logic [23:0] rgn,
			input logic rtc_on, input logic [31:0] rtc_txt, input logic [1:0] prio,
			input logic auto_off);
		dl_addr_t   last;
		logic [7:0] bi;
		int         tail;
		build_image(id, crc, rgn);
		rng  = xorshift32(rng);
		tail = int'(rng % 32'd8);
		last = (rtc_on ? RTC_ID_DONE : HDR_END) + 25'(2 * tail);
		{exp_eeprom, exp_bank, exp_noram, exp_pier, exp_svp, exp_fmbusy, exp_schan, exp_sf,
			exp_realtec, exp_gun, exp_delay, exp_region, exp_rom_sz} =
			predict_result(id, crc, rgn, rtc_on, rtc_txt, prio, auto_off, exp_region, last);
		region_priority = prio;
		auto_region_off = auto_off;
		cart_download   = 1'b1;
		@(negedge clk_sys);
		for (int k = 0; k < 65; k++) begin
			bi = 8'(2 * k);
			write_word(HDR_ID_BASE + 25'(2 * k), {img[bi + 8'd1], img[bi]});
		end
		if (rtc_on) begin
			write_word(RTC_ID_HI, {rtc_txt[23:16], rtc_txt[31:24]});
			write_word(RTC_ID_LO, {rtc_txt[7:0], rtc_txt[15:8]});
			write_word(RTC_ID_DONE, 16'h0000);
		end
		for (int t = 1; t <= tail; t++) begin
			rng = xorshift32(rng);
			write_word(last - 25'(2 * (tail - t)), rng[15:0]);
		end
		repeat (4) @(negedge clk_sys);
		request_check(!auto_off, 1'b0);   // Region held while the download runs
		cart_download = 1'b0;
		repeat (4) @(negedge clk_sys);
		request_check(1'b0, 1'b1);
	endtask

	// Run limit
	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		clk_sys         = 1'b0;
		RESET           = 1'b1;
		cart_download   = 1'b0;
		dl_wr           = 1'b0;
		dl_addr         = '0;
		dl_data         = '0;
		auto_region_off = 1'b0;
		region_priority = 2'd0;
		rng             = 32'd54216;
		err_cnt         = 0;
		check_cnt       = 0;
		cycle_cnt       = 0;
		{exp_eeprom, exp_bank, exp_noram, exp_pier, exp_svp, exp_fmbusy, exp_schan} = '0;
		exp_sf      = '0;
		exp_realtec = 1'b0;
		exp_gun     = 1'b0;
		exp_delay   = GUN_DELAY_DEFAULT;
		exp_region  = REGION_JP;
		exp_rom_sz  = '0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		$display("Test 1: values after reset");
		request_check(1'b0, 1'b0);

		$display("Test 2: letter region codes");
		for (int p = 0; p < 4; p++) begin
			for (int i = 0; i < 4; i++)
				run_download(PLAIN_ID, 16'h1111, letter_codes[i], 1'b0, "    ", 2'(p), 1'b0);
		end
		run_download(PLAIN_ID, 16'h1111, "E  ", 1'b0, "    ", 2'd1, 1'b1);

		$display("Test 3: digit and hex region codes");
		// Each code is paired with an order whose head is not the decoded region
		for (int i = 0; i < 5; i++)
			run_download(PLAIN_ID, 16'h2222, digit_codes[i], 1'b0, "    ", 2'(i + 3), 1'b0);

		$display("Test 4: per-title quirks");
		for (int i = 0; i < 13; i++)
			run_download(quirk_ids[i], quirk_crcs[i], "U  ", 1'b0, "    ", 2'd0, 1'b0);
		run_download(PLAIN_ID, 16'h2222, "U  ", 1'b0, "    ", 2'd0, 1'b0);

		$display("Test 5: light-gun titles and secondary ID");
		for (int i = 0; i < 6; i++)
			run_download(gun_ids[i], 16'h3333, "J  ", 1'b0, "    ", 2'd3, 1'b0);
		run_download(PLAIN_ID, 16'h4444, "U  ", 1'b1, "SEGA", 2'd0, 1'b0);
		run_download(PLAIN_ID, 16'h4444, "U  ", 1'b1, "SEGB", 2'd0, 1'b0);

		repeat (2) @(negedge clk_sys);
		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+src
src/cart_hdr_pkg.sv
src/dl_word_capture.sv
src/header_field_latch.sv
src/cart_quirk_decode.sv
src/region_resolver.sv
src/cart_header_top.sv
sim/tb_cart_header.sv

// File: Makefile
# Verilator build and run of the cartridge header testbench

VERILATOR ?= verilator
TOP       ?= tb_cart_header
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= CHECKS FAILED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
